// File: common/isa_pkg.sv
package isa_pkg;

    localparam int XLEN    = 32;
    localparam int NIBBLES = XLEN / 4;   // alu steps per word

    // base opcodes, only the supported subset
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111
    } opcode_e;

    // R-type field view, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    function automatic logic [XLEN-1:0] imm_i(input logic [31:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [31:0] instr);
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};   // split around rd slot
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [31:0] instr);
        return {instr[31:12], 12'b0};
    endfunction

    // jump offset, bit 0 always zero
    function automatic logic [XLEN-1:0] imm_j(input logic [31:0] instr);
        return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

endpackage

// File: common/core_pkg.sv
package core_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        RESET,
        INSTR_FETCH,
        DECODE,
        EXECUTE,
        MEM_ACCESS,
        WRITE_BACK,
        ERROR          // sticky until rst_n
    } state_e;

    typedef enum logic [0:0] {
        ADD,
        PASS_B         // lui, immediate copied through the nibble loop
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] addr;   // byte address, word aligned
        logic [XLEN-1:0] wdata;
        logic            we;
        logic            re;
    } mem_req_t;

    typedef struct packed {
        logic [4:0]      rd;      // zero for sw
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] next_pc;
    } retire_t;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // x0 cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin   // writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

    // async read ports, control samples them in the same cycle
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

// File: source/ram.sv
`timescale 1ns/1ps

module ram
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int MEM_BYTES = 1024
) (
    input  logic            clk,
    input  logic            run,
    input  mem_req_t        req,
    output logic [XLEN-1:0] rdata,
    input  logic            ext_we,
    input  logic [XLEN-1:0] ext_addr,
    input  logic [XLEN-1:0] ext_wdata,
    output logic [XLEN-1:0] ext_rdata
);

    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];

    logic [AW-1:0]   core_base;
    logic [AW-1:0]   ext_base;
    logic [AW-1:0]   wr_base;
    logic [XLEN-1:0] wr_data;
    logic            wr_en;
    logic [XLEN-1:0] core_word;
    logic [XLEN-1:0] ext_word;

    assign core_base = req.addr[AW-1:0];   // upper bits range checked in control
    assign ext_base  = ext_addr[AW-1:0];

    // run hands the write port to the core, else the loader owns it
    assign wr_base = run ? core_base : ext_base;
    assign wr_data = run ? req.wdata : ext_wdata;
    assign wr_en   = run ? req.we    : ext_we;

    // little endian, lowest byte at the base address
    assign core_word = {mem[core_base + AW'(3)], mem[core_base + AW'(2)],
                        mem[core_base + AW'(1)], mem[core_base]};
    assign ext_word  = {mem[ext_base + AW'(3)], mem[ext_base + AW'(2)],
                        mem[ext_base + AW'(1)], mem[ext_base]};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                mem[wr_base + AW'(i)] <= wr_data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run && req.re) begin
            rdata <= core_word;   // held until the next strobe
        end
        ext_rdata <= ext_word;    // loader readback, one cycle behind ext_addr
    end

endmodule

// File: control/nibble_alu.sv
`timescale 1ns/1ps

module nibble_alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output logic [XLEN-1:0] result
);

    localparam int IDX_W = $clog2(NIBBLES);

    logic             busy;
    logic [IDX_W-1:0] idx;      // nibble under work
    logic             carry;
    logic [XLEN-1:0]  shreg;    // finished nibbles enter at the top
    logic [3:0]       nib_a;
    logic [3:0]       nib_b;
    logic [4:0]       sum;
    logic [3:0]       nib_res;

    assign nib_a   = a[idx*4 +: 4];
    assign nib_b   = b[idx*4 +: 4];
    assign sum     = {1'b0, nib_a} + {1'b0, nib_b} + {4'b0, carry};
    assign nib_res = (op == PASS_B) ? nib_b : sum[3:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            idx   <= '0;
            carry <= 1'b0;
        end else if (start) begin   // restart wins over a running pass
            busy  <= 1'b1;
            idx   <= '0;
            carry <= 1'b0;
        end else if (busy) begin
            idx   <= idx + 1'b1;
            carry <= (op == ADD) && sum[4];
            if (idx == IDX_W'(NIBBLES - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            shreg <= {nib_res, shreg[XLEN-1:4]};
        end
    end

    // last nibble goes straight to the output, no extra cycle
    assign done   = busy && (idx == IDX_W'(NIBBLES - 1));
    assign result = {nib_res, shreg[XLEN-1:4]};

endmodule

// File: control/control.sv
`timescale 1ns/1ps

module control
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] START_ADDR = 32'h0000_0100,
    parameter int              MEM_BYTES  = 1024
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    output mem_req_t        mem_req,
    input  logic [XLEN-1:0] mem_rdata,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    input  logic [XLEN-1:0] rd1,
    input  logic [XLEN-1:0] rd2,
    output logic            rf_we,
    output logic [4:0]      rf_waddr,
    output logic [XLEN-1:0] rf_wdata,
    output logic            alu_start,
    output alu_op_e         alu_op,
    output logic [XLEN-1:0] op_a,
    output logic [XLEN-1:0] op_b,
    input  logic            alu_done,
    input  logic [XLEN-1:0] alu_result,
    output logic            retire,
    output retire_t         retire_info,
    output logic            error,
    output logic [XLEN-1:0] pc
);

    state_e          state;
    state_e          state_nxt;
    instr_fields_t   ir;
    instr_fields_t   instr;        // live view, straight from ram during decode
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_q;        // address for lw/sw, result otherwise
    logic [XLEN-1:0] jal_target;
    logic [XLEN-1:0] next_pc;
    logic            link_pass;    // second jal pass, pc + 4
    logic            opcode_ok;
    logic            is_load;
    logic            is_store;
    logic            is_jal;

    // word aligned and fully inside the ram
    function automatic logic addr_ok(input logic [XLEN-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr <= XLEN'(MEM_BYTES - 4));
    endfunction

    assign instr    = (state == DECODE) ? instr_fields_t'(mem_rdata) : ir;
    assign is_load  = (instr.opcode == LOAD);
    assign is_store = (instr.opcode == STORE);
    assign is_jal   = (instr.opcode == JAL);
    assign rs1      = instr.rs1;
    assign rs2      = instr.rs2;   // sw data

    always_comb begin
        imm       = '0;
        opcode_ok = 1'b0;
        case (instr.opcode)
            OP_IMM: begin
                imm       = imm_i(instr);
                opcode_ok = (instr.funct3 == 3'b000);   // addi only
            end
            LOAD: begin
                imm       = imm_i(instr);
                opcode_ok = (instr.funct3 == 3'b010);   // word access only
            end
            STORE: begin
                imm       = imm_s(instr);
                opcode_ok = (instr.funct3 == 3'b010);
            end
            LUI, AUIPC: begin
                imm       = imm_u(instr);
                opcode_ok = 1'b1;
            end
            JAL: begin
                imm       = imm_j(instr);
                opcode_ok = 1'b1;
            end
            default: ;
        endcase
    end

    // operand steering, levels stay put while the alu loops
    always_comb begin
        alu_op = ADD;
        op_a   = rd1;   // addi, lw, sw base
        op_b   = imm;
        case (instr.opcode)
            LUI:   alu_op = PASS_B;
            AUIPC: op_a = pc;
            JAL: begin
                op_a = pc;
                if (link_pass) begin
                    op_b = XLEN'(4);
                end
            end
            default: ;
        endcase
    end

    assign alu_start = ((state == DECODE) && opcode_ok) ||
                       ((state == EXECUTE) && alu_done && is_jal && !link_pass);

    always_comb begin
        state_nxt = state;
        case (state)
            RESET:       if (run) state_nxt = INSTR_FETCH;
            INSTR_FETCH: state_nxt = addr_ok(pc) ? DECODE : ERROR;
            DECODE:      state_nxt = opcode_ok ? EXECUTE : ERROR;
            EXECUTE: begin
                if (alu_done) begin
                    if (is_load || is_store) begin
                        state_nxt = addr_ok(alu_result) ? MEM_ACCESS : ERROR;
                    end else if (!(is_jal && !link_pass)) begin   // jal loops once more
                        state_nxt = WRITE_BACK;
                    end
                end
            end
            MEM_ACCESS:  state_nxt = WRITE_BACK;
            WRITE_BACK:  state_nxt = INSTR_FETCH;
            default:     state_nxt = ERROR;
        endcase
        if (!run && state != ERROR) begin   // drop whatever is in flight
            state_nxt = RESET;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RESET;
            pc        <= START_ADDR;
            link_pass <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == RESET) begin
                pc <= START_ADDR;   // every run starts over
            end else if (state == WRITE_BACK) begin
                pc <= next_pc;
            end
            if (state == DECODE) begin
                link_pass <= 1'b0;
            end else if (state == EXECUTE && alu_done && is_jal) begin
                link_pass <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir <= instr_fields_t'(mem_rdata);
        end
        if (state == EXECUTE && alu_done) begin
            if (is_jal && !link_pass) begin
                jal_target <= alu_result;
            end else begin
                alu_q <= alu_result;
            end
        end
    end

    // sequential step, jal takes its computed target
    assign next_pc = is_jal ? jal_target : pc + XLEN'(4);

    assign mem_req.addr  = (state == INSTR_FETCH) ? pc : alu_q;
    assign mem_req.wdata = rd2;
    assign mem_req.we    = (state == MEM_ACCESS) && is_store;
    assign mem_req.re    = (state == INSTR_FETCH) || ((state == MEM_ACCESS) && is_load);

    // lw data arrives from ram in writeback
    assign rf_we    = (state == WRITE_BACK) && !is_store;
    assign rf_waddr = ir.rd;
    assign rf_wdata = is_load ? mem_rdata : alu_q;

    assign retire      = (state == WRITE_BACK);
    assign retire_info = '{rd:      is_store ? 5'd0 : ir.rd,
                           value:   is_store ? rd2 : rf_wdata,
                           next_pc: next_pc};
    assign error       = (state == ERROR);

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] START_ADDR = 32'h0000_0100,
    parameter int              MEM_BYTES  = 1024
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  logic            ext_we,
    input  logic [XLEN-1:0] ext_addr,
    input  logic [XLEN-1:0] ext_wdata,
    output logic [XLEN-1:0] ext_rdata,
    output logic            retire,
    output retire_t         retire_info,
    output logic            error,
    output logic [XLEN-1:0] pc
);

    mem_req_t        mem_req;
    logic [XLEN-1:0] mem_rdata;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    logic            alu_start;
    alu_op_e         alu_op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            alu_done;
    logic [XLEN-1:0] alu_result;

    control #(
        .START_ADDR (START_ADDR),
        .MEM_BYTES  (MEM_BYTES)
    ) i_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd1         (rd1),
        .rd2         (rd2),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .alu_start   (alu_start),
        .alu_op      (alu_op),
        .op_a        (op_a),
        .op_b        (op_b),
        .alu_done    (alu_done),
        .alu_result  (alu_result),
        .retire      (retire),
        .retire_info (retire_info),
        .error       (error),
        .pc          (pc)
    );

    nibble_alu i_nibble_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (alu_start),
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .done   (alu_done),
        .result (alu_result)
    );

    register_file i_register_file (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    ram #(
        .MEM_BYTES (MEM_BYTES)
    ) i_ram (
        .clk       (clk),
        .run       (run),
        .req       (mem_req),
        .rdata     (mem_rdata),
        .ext_we    (ext_we),
        .ext_addr  (ext_addr),
        .ext_wdata (ext_wdata),
        .ext_rdata (ext_rdata)
    );

endmodule

// File: tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// two dependent adds with the carry running through every nibble
task automatic addi_chain();
    logic [11:0] imm1;
    logic [11:0] imm2;
    logic [31:0] x1_val;
    bit          ok;
    imm1   = 12'(random_bits(12));
    imm2   = 12'(random_bits(12));
    x1_val = sext12(imm1);
    write_word(START_ADDR, i_format(OP_IMM, 5'd1, 3'b000, 5'd0, imm1));
    write_word(START_ADDR + 4, i_format(OP_IMM, 5'd5, 3'b000, 5'd1, imm2));
    run_program(2, ok);
    if (ok) begin
        check_retire(0, START_ADDR, 5'd1, x1_val, START_ADDR + 4);
        check_retire(1, START_ADDR + 4, 5'd5, x1_val + sext12(imm2), START_ADDR + 8);
    end
endtask

task automatic load_offsets();
    logic [31:0] word_hi;
    logic [31:0] word_lo;
    bit          ok;
    word_hi = random_bits(32);
    word_lo = random_bits(32);
    write_word(32'h200, word_hi);
    write_word(32'h1e0, word_lo);
    write_word(START_ADDR, i_format(OP_IMM, 5'd2, 3'b000, 5'd0, 12'h1f0));   // base
    write_word(START_ADDR + 4, i_format(LOAD, 5'd3, 3'b010, 5'd2, 12'h010));
    write_word(START_ADDR + 8, i_format(LOAD, 5'd4, 3'b010, 5'd2, 12'hff0));  // -16
    run_program(3, ok);
    if (ok) begin
        check_retire(0, START_ADDR, 5'd2, 32'h1f0, START_ADDR + 4);
        check_retire(1, START_ADDR + 4, 5'd3, word_hi, START_ADDR + 8);
        check_retire(2, START_ADDR + 8, 5'd4, word_lo, START_ADDR + 12);
    end
endtask

task automatic store_readback();
    logic [11:0] imm;
    logic [31:0] value;
    logic [31:0] back;
    bit          ok;
    imm   = 12'(random_bits(12));
    value = sext12(imm);
    write_word(32'h248, ~value);   // stale word that sw must replace
    write_word(START_ADDR, i_format(OP_IMM, 5'd6, 3'b000, 5'd0, imm));
    write_word(START_ADDR + 4, i_format(OP_IMM, 5'd7, 3'b000, 5'd0, 12'h240));
    write_word(START_ADDR + 8, s_format(5'd6, 5'd7, 12'h008));
    run_program(3, ok);
    if (ok) begin
        check_value("pc (sw)", retired_pc[2], START_ADDR + 8);
        check_value("retire_info.rd (sw)", 32'(retired[2].rd), 32'd0);
        check_value("retire_info.next_pc (sw)", retired[2].next_pc, START_ADDR + 12);
    end
    read_word(32'h248, back);
    check_value("ext_rdata", back, value);
endtask

task automatic upper_immediates();
    logic [19:0] upper_a;
    logic [19:0] upper_b;
    bit          ok;
    upper_a = 20'(random_bits(20));
    upper_b = 20'(random_bits(20));
    write_word(START_ADDR, u_format(LUI, 5'd8, upper_a));
    write_word(START_ADDR + 4, u_format(AUIPC, 5'd9, upper_b));
    run_program(2, ok);
    if (ok) begin
        check_retire(0, START_ADDR, 5'd8, {upper_a, 12'b0}, START_ADDR + 4);
        check_retire(1, START_ADDR + 4, 5'd9, START_ADDR + 4 + {upper_b, 12'b0},
                     START_ADDR + 8);   // own pc
    end
endtask

// jal at +8 jumps back to the program start
task automatic jump_and_link();
    bit ok;
    write_word(START_ADDR, i_format(OP_IMM, 5'd1, 3'b000, 5'd0, 12'h001));
    write_word(START_ADDR + 4, i_format(OP_IMM, 5'd2, 3'b000, 5'd0, 12'h002));
    write_word(START_ADDR + 8, j_format(5'd5, 21'h1f_fff8));   // -8
    run_program(3, ok);
    if (ok) begin
        check_value("retire_info.next_pc (retire 1)", retired[1].next_pc, START_ADDR + 8);
        check_retire(2, START_ADDR + 8, 5'd5, START_ADDR + 12, START_ADDR);
    end
endtask

task automatic error_recovery();
    int cycles;
    bit seen;
    write_word(START_ADDR, 32'h0000_0033);   // R-type add is outside the subset
    retired.delete();
    retired_pc.delete();
    @(posedge clk);
    run <= 1'b1;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 40) begin
        @(negedge clk);
        seen = error;
        cycles++;
    end
    assert (seen) else begin
        $display("error did not rise within 40 cycles of an undefined opcode");
        other_errors++;
    end
    repeat (40) @(posedge clk);   // core must stay parked
    assert (retired.size() == 0) else begin
        $display("core retired %0d instructions after entering error", retired.size());
        other_errors++;
    end
    @(negedge clk);
    check_value("error", 32'(error), 32'd1);   // sticky with run still high
    @(posedge clk);
    rst_n <= 1'b0;
    run   <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("error", 32'(error), 32'd0);
    check_value("retire", 32'(retire), 32'd0);
    addi_chain();   // fresh program after reset
endtask

`endif

// File: tests/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam logic [31:0] START_ADDR = 32'h0000_0100;
    localparam int          MEM_BYTES  = 1024;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        ext_we;
    logic [31:0] ext_addr;
    logic [31:0] ext_wdata;
    logic [31:0] ext_rdata;
    logic        retire;
    retire_t     retire_info;
    logic        error;
    logic [31:0] pc;

    retire_t     retired [$];      // retire pulses seen since the last run started
    logic [31:0] retired_pc [$];   // pc output during each of those pulses
    logic [31:0] lfsr_state;
    int          checks;
    int          value_errors;
    int          other_errors;   // timeouts and missing or extra events

    cpu_top #(
        .START_ADDR (START_ADDR),
        .MEM_BYTES  (MEM_BYTES)
    ) i_cpu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .ext_we      (ext_we),
        .ext_addr    (ext_addr),
        .ext_wdata   (ext_wdata),
        .ext_rdata   (ext_rdata),
        .retire      (retire),
        .retire_info (retire_info),
        .error       (error),
        .pc          (pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // retire outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && retire) begin
            retired.push_back(retire_info);
            retired_pc.push_back(pc);
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // newest bit lands in bit 0
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] i_format(input opcode_e op, input logic [4:0] rd,
                                             input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_format(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};   // sw only
    endfunction

    function automatic logic [31:0] u_format(input opcode_e op, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // offset scrambled into the J layout with bit 0 dropped
    function automatic logic [31:0] j_format(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_retire(input int idx, input logic [31:0] own_pc,
                                input logic [4:0] rd, input logic [31:0] value,
                                input logic [31:0] next_pc);
        check_value($sformatf("pc (retire %0d)", idx), retired_pc[idx], own_pc);
        check_value($sformatf("retire_info.rd (retire %0d)", idx), 32'(retired[idx].rd),
                    32'(rd));
        check_value($sformatf("retire_info.value (retire %0d)", idx), retired[idx].value,
                    value);
        check_value($sformatf("retire_info.next_pc (retire %0d)", idx),
                    retired[idx].next_pc, next_pc);
    endtask

    // loader port used only while run is low
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        ext_we    <= 1'b1;
        ext_addr  <= addr;
        ext_wdata <= data;
        @(posedge clk);   // word lands on this edge
        ext_we <= 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        ext_addr <= addr;
        @(posedge clk);   // ext_rdata registered here
        @(negedge clk);
        data = ext_rdata;
    endtask

    // runs from START_ADDR and stops right after the given number of retires
    task automatic run_program(input int count, output bit ok);
        int cycles;
        cycles = 0;
        retired.delete();
        retired_pc.delete();
        @(posedge clk);
        run <= 1'b1;
        while (retired.size() < count && cycles < 40 * count) begin
            @(posedge clk);
            cycles++;
        end
        run <= 1'b0;      // next fetch is dropped
        @(posedge clk);
        ok = (retired.size() >= count);
        assert (ok) else begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired.size(), count);
            other_errors++;
        end
    endtask

    `include "tb_tasks.svh"

    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        ext_we     = 1'b0;
        ext_addr   = '0;
        ext_wdata  = '0;
        lfsr_state = 32'h0eb7f8fa;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        addi_chain();
        load_offsets();
        store_readback();
        upper_immediates();
        jump_and_link();
        error_recovery();

        $display("value checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+tests
common/isa_pkg.sv
common/core_pkg.sv
source/register_file.sv
source/ram.sv
control/nibble_alu.sv
control/control.sv
source/cpu_top.sv
tests/tb_cpu.sv
